//--- src/miner_link_pkg.sv
package miner_link_pkg;

    // one uart character.
    localparam int byte_width = 8;

    // block header as sent by the host.
    localparam int header_bytes = 80;
    localparam int header_width = header_bytes * byte_width;

    // nonce returned by the hashing core, sent msb first.
    localparam int nonce_bytes = 4;
    localparam int nonce_width = nonce_bytes * byte_width;

    // wide enough to hold header_bytes.
    localparam int byte_count_width = 7;

endpackage

//--- src/uart_rx.sv
`timescale 1ns/100ps

module uart_rx #(
    parameter int clks_per_bit = 868
) (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  rxd,
    output logic [miner_link_pkg::byte_width-1:0] rx_byte,
    output logic                                  rx_valid
);
    import miner_link_pkg::*;

    localparam int cnt_width = $clog2(clks_per_bit);
    localparam int idx_width = $clog2(byte_width);
    localparam logic [cnt_width-1:0] full_bit = cnt_width'(clks_per_bit - 1);
    localparam logic [cnt_width-1:0] half_bit = cnt_width'(clks_per_bit / 2 - 1);
    localparam logic [idx_width-1:0] last_bit = idx_width'(byte_width - 1);

    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop,
        rx_tail
    } rx_state_t;

    rx_state_t             state;
    logic                  rxd_meta;
    logic                  rxd_sync;
    logic [cnt_width-1:0]  cnt;
    logic [idx_width-1:0]  bit_idx;
    logic                  stop_ok;
    logic [byte_width-1:0] shift;

    // the line idles high, so the synchronizer resets high too.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= rx_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            stop_ok  <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (!rxd_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // line must still be low at mid start bit, else it was a glitch.
                    if (cnt == half_bit) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? rx_idle : rx_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (cnt == full_bit) begin
                        cnt <= '0;
                        if (bit_idx == last_bit) begin
                            state <= rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (cnt == full_bit) begin
                        cnt     <= '0;
                        stop_ok <= rxd_sync;
                        state   <= rx_tail;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_tail: begin
                    // a framing error just drops the byte.
                    if (cnt == half_bit) begin
                        rx_valid <= stop_ok;
                        state    <= rx_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // lsb arrives first.
    always_ff @(posedge clock) begin
        if (state == rx_data && cnt == full_bit) begin
            shift <= {rxd_sync, shift[byte_width-1:1]};
        end
    end

    assign rx_byte = shift;

endmodule

//--- src/uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
    parameter int clks_per_bit = 868
) (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  tx_start,
    input  logic [miner_link_pkg::byte_width-1:0] tx_byte,
    output logic                                  txd,
    output logic                                  tx_busy
);
    import miner_link_pkg::*;

    localparam int frame_width = byte_width + 2;
    localparam int cnt_width = $clog2(clks_per_bit);
    localparam int idx_width = $clog2(frame_width);
    localparam logic [cnt_width-1:0] full_bit = cnt_width'(clks_per_bit - 1);
    localparam logic [idx_width-1:0] last_bit = idx_width'(frame_width - 1);

    logic [frame_width-1:0] frame;
    logic [cnt_width-1:0]   cnt;
    logic [idx_width-1:0]   bit_idx;

    // frame shifts right and fills with ones, so txd rests at the idle level.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            frame   <= '1;
            cnt     <= '0;
            bit_idx <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            cnt     <= '0;
            bit_idx <= '0;
            if (tx_start) begin
                frame   <= {1'b1, tx_byte, 1'b0};
                tx_busy <= 1'b1;
            end
        end else if (cnt == full_bit) begin
            cnt   <= '0;
            frame <= {1'b1, frame[frame_width-1:1]};
            if (bit_idx == last_bit) begin
                tx_busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign txd = frame[0];

    // the serializer may only advance between characters.
    assert property (@(posedge clock) disable iff (!rst_n) tx_busy |-> $stable(tx_byte))
        else $error("uart_tx: tx_byte changed while tx_busy was high");

endmodule

//--- src/header_assembler.sv
`timescale 1ns/100ps

module header_assembler (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic [miner_link_pkg::byte_width-1:0]   rx_byte,
    input  logic                                    rx_valid,
    input  logic                                    byte_enable,
    input  logic                                    start_new,
    output logic [miner_link_pkg::header_width-1:0] header_data,
    output logic                                    header_full
);
    import miner_link_pkg::*;

    logic [byte_count_width-1:0] byte_count;
    logic                        take;

    assign take = rx_valid && byte_enable;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            byte_count <= '0;
        end else if (start_new) begin
            byte_count <= '0;
        end else if (take) begin
            byte_count <= byte_count + 1'b1;
        end
    end

    // new bytes enter at the bottom, so the first byte ends up on top.
    always_ff @(posedge clock) begin
        if (take) begin
            header_data <= {header_data[header_width-byte_width-1:0], rx_byte};
        end
    end

    assign header_full = (byte_count == byte_count_width'(header_bytes));

endmodule

//--- src/nonce_serializer.sv
`timescale 1ns/100ps

module nonce_serializer (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  logic [miner_link_pkg::nonce_width-1:0] nonce,
    input  logic                                   capture,
    input  logic                                   next_byte,
    output logic [miner_link_pkg::byte_width-1:0]  tx_byte,
    output logic                                   bytes_left_zero
);
    import miner_link_pkg::*;

    localparam int count_width = $clog2(nonce_bytes + 1);

    logic [nonce_width-1:0] shift;
    logic [count_width-1:0] count;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (capture) begin
            count <= count_width'(nonce_bytes);
        end else if (next_byte && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // msb first on the wire.
    always_ff @(posedge clock) begin
        if (capture) begin
            shift <= nonce;
        end else if (next_byte) begin
            shift <= {shift[nonce_width-byte_width-1:0], {byte_width{1'b0}}};
        end
    end

    assign tx_byte         = shift[nonce_width-1 -: byte_width];
    assign bytes_left_zero = (count == '0);

endmodule

//--- src/link_ctrl.sv
`timescale 1ns/100ps

module link_ctrl (
    input  logic clock,
    input  logic rst_n,
    input  logic header_full,
    input  logic header_ack,
    input  logic nonce_req,
    input  logic tx_busy,
    input  logic bytes_left_zero,
    input  logic rx_valid,
    output logic header_req,
    output logic byte_enable,
    output logic start_new,
    output logic nonce_ack,
    output logic capture,
    output logic next_byte,
    output logic tx_start,
    output logic overrun
);

    typedef enum logic [1:0] {
        hdr_collect,
        hdr_offer,
        hdr_release
    } hdr_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_launch,
        tx_wait
    } tx_state_t;

    hdr_state_t hdr_state;
    tx_state_t  tx_state;

    // header delivery.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hdr_state  <= hdr_collect;
            header_req <= 1'b0;
        end else begin
            case (hdr_state)
                hdr_collect: begin
                    if (header_full) begin
                        header_req <= 1'b1;
                        hdr_state  <= hdr_offer;
                    end
                end
                hdr_offer: begin
                    if (header_ack) begin
                        header_req <= 1'b0;
                        hdr_state  <= hdr_release;
                    end
                end
                hdr_release: begin
                    if (!header_ack) begin
                        hdr_state <= hdr_collect;
                    end
                end
                default: hdr_state <= hdr_collect;
            endcase
        end
    end

    // header_data is frozen from header_full until the core lets go of ack.
    assign byte_enable = (hdr_state == hdr_collect) && !header_full;
    assign start_new   = (hdr_state == hdr_release) && !header_ack;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            overrun <= 1'b0;
        end else if (rx_valid && !byte_enable) begin
            overrun <= 1'b1;
        end
    end

    // nonce return. ack is held back until the previous nonce is fully sent.
    assign capture = !nonce_ack && nonce_req && (tx_state == tx_idle) && !tx_busy
                     && bytes_left_zero;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            nonce_ack <= 1'b0;
        end else if (capture) begin
            nonce_ack <= 1'b1;
        end else if (nonce_ack && !nonce_req) begin
            nonce_ack <= 1'b0;
        end
    end

    // character sequencer.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tx_state <= tx_idle;
        end else begin
            case (tx_state)
                tx_idle: begin
                    if (capture) begin
                        tx_state <= tx_launch;
                    end
                end
                tx_launch: tx_state <= bytes_left_zero ? tx_idle : tx_wait;
                tx_wait: begin
                    if (!tx_busy) begin
                        tx_state <= tx_launch;
                    end
                end
                default: tx_state <= tx_idle;
            endcase
        end
    end

    // advance right after a character so the next byte is ready at launch.
    assign next_byte = (tx_state == tx_wait) && !tx_busy;
    assign tx_start  = (tx_state == tx_launch) && !bytes_left_zero;

    assert property (@(posedge clock) disable iff (!rst_n)
        $fell(header_req) |-> $past(header_ack))
        else $error("link_ctrl: header_req dropped without header_ack");

    assert property (@(posedge clock) disable iff (!rst_n) tx_start |-> !tx_busy)
        else $error("link_ctrl: tx_start while uart_tx busy");

endmodule

//--- src/miner_uart_link.sv
`timescale 1ns/100ps

module miner_uart_link #(
    parameter int clks_per_bit = 868
) (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic                                    rxd,
    input  logic                                    header_ack,
    input  logic                                    nonce_req,
    input  logic [miner_link_pkg::nonce_width-1:0]  nonce,
    output logic                                    txd,
    output logic                                    header_req,
    output logic [miner_link_pkg::header_width-1:0] header_data,
    output logic                                    nonce_ack,
    output logic                                    overrun
);
    import miner_link_pkg::*;

    logic [byte_width-1:0] rx_byte;
    logic [byte_width-1:0] tx_byte;
    logic                  rx_valid;
    logic                  header_full;
    logic                  byte_enable;
    logic                  start_new;
    logic                  capture;
    logic                  next_byte;
    logic                  bytes_left_zero;
    logic                  tx_start;
    logic                  tx_busy;

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) u_uart_rx (
        .clock   (clock),
        .rst_n   (rst_n),
        .rxd     (rxd),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid)
    );

    header_assembler u_header_assembler (
        .clock      (clock),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .byte_enable(byte_enable),
        .start_new  (start_new),
        .header_data(header_data),
        .header_full(header_full)
    );

    nonce_serializer u_nonce_serializer (
        .clock          (clock),
        .rst_n          (rst_n),
        .nonce          (nonce),
        .capture        (capture),
        .next_byte      (next_byte),
        .tx_byte        (tx_byte),
        .bytes_left_zero(bytes_left_zero)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) u_uart_tx (
        .clock   (clock),
        .rst_n   (rst_n),
        .tx_start(tx_start),
        .tx_byte (tx_byte),
        .txd     (txd),
        .tx_busy (tx_busy)
    );

    link_ctrl u_link_ctrl (
        .clock          (clock),
        .rst_n          (rst_n),
        .header_full    (header_full),
        .header_ack     (header_ack),
        .nonce_req      (nonce_req),
        .tx_busy        (tx_busy),
        .bytes_left_zero(bytes_left_zero),
        .rx_valid       (rx_valid),
        .header_req     (header_req),
        .byte_enable    (byte_enable),
        .start_new      (start_new),
        .nonce_ack      (nonce_ack),
        .capture        (capture),
        .next_byte      (next_byte),
        .tx_start       (tx_start),
        .overrun        (overrun)
    );

endmodule

//--- testbench/tb_miner_uart_link.sv
`timescale 1ns/100ps

module tb_miner_uart_link;
    import miner_link_pkg::*;

    localparam int clks_per_bit = 16;
    localparam int drive_delay = 2;

    logic                    clock;
    logic                    rst_n;
    logic                    rxd;
    logic                    header_ack;
    logic                    nonce_req;
    logic [nonce_width-1:0]  nonce;
    logic                    txd;
    logic                    header_req;
    logic [header_width-1:0] header_data;
    logic                    nonce_ack;
    logic                    overrun;

    logic [31:0]             lfsr;
    logic [header_width-1:0] expected_header;
    logic [byte_width-1:0]   expected_chars[$];
    logic                    overrun_expected;
    int                      chars_pending;
    int                      errors;
    int                      errors_before;
    int                      test_count;
    logic [nonce_width-1:0]  first_nonce;
    logic [nonce_width-1:0]  second_nonce;

    miner_uart_link #(
        .clks_per_bit(clks_per_bit)
    ) DUT (
        .clock      (clock),
        .rst_n      (rst_n),
        .rxd        (rxd),
        .header_ack (header_ack),
        .nonce_req  (nonce_req),
        .nonce      (nonce),
        .txd        (txd),
        .header_req (header_req),
        .header_data(header_data),
        .nonce_ack  (nonce_ack),
        .overrun    (overrun)
    );

    always #10 clock = ~clock;

    function automatic logic next_random_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'hd000_0001;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #drive_delay;
    endtask

    task automatic expect_bit(input string name, input logic got, input logic want);
        assert (got === want) else begin
            $display("** Error: %s = %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    // 8N1 host character, then one idle bit so the receiver can rearm.
    task automatic send_byte(input logic [byte_width-1:0] value, input logic stop_level);
        rxd = 1'b0;
        repeat (clks_per_bit) next_cycle();
        for (int i = 0; i < byte_width; i++) begin
            rxd = value[i];
            repeat (clks_per_bit) next_cycle();
        end
        rxd = stop_level;
        repeat (clks_per_bit) next_cycle();
        rxd = 1'b1;
        repeat (clks_per_bit) next_cycle();
    endtask

    task automatic send_header_bytes(input int count);
        logic [byte_width-1:0] value;
        for (int i = 0; i < count; i++) begin
            value = byte_width'(random_bits(byte_width));
            expected_header = {expected_header[header_width-byte_width-1:0], value};
            send_byte(value, 1'b1);
        end
    endtask

    task automatic wait_header_req(input logic level, input int limit);
        int n;
        n = 0;
        while (header_req !== level && n < limit) begin
            next_cycle();
            n++;
        end
        if (header_req !== level) begin
            $display("timeout waiting for header_req to become %0d", level);
            errors++;
        end
    endtask

    task automatic ack_header();
        header_ack = 1'b1;
        wait_header_req(1'b0, 20);
        header_ack = 1'b0;
        next_cycle();
    endtask

    task automatic wait_nonce_ack(input logic level, input int limit);
        int n;
        n = 0;
        while (nonce_ack !== level && n < limit) begin
            next_cycle();
            n++;
        end
        if (nonce_ack !== level) begin
            $display("timeout waiting for nonce_ack to become %0d", level);
            errors++;
        end
    endtask

    // hashing core side of the nonce handshake.
    task automatic offer_nonce(input logic [nonce_width-1:0] value);
        nonce = value;
        nonce_req = 1'b1;
        wait_nonce_ack(1'b1, 4000);
        for (int i = nonce_bytes - 1; i >= 0; i--) begin
            expected_chars.push_back(value[i*byte_width +: byte_width]);
        end
        chars_pending += nonce_bytes;
        nonce_req = 1'b0;
        wait_nonce_ack(1'b0, 20);
    endtask

    task automatic wait_pending_below(input int level, input int limit);
        int n;
        n = 0;
        while (chars_pending >= level && n < limit) begin
            next_cycle();
            n++;
        end
        if (chars_pending >= level) begin
            $display("timeout waiting for a nonce character to leave txd");
            errors++;
        end
    endtask

    // samples txd at the middle of each bit.
    task automatic receive_chars(input int count);
        logic [byte_width-1:0] got;
        logic [byte_width-1:0] want;
        int n;
        for (int c = 0; c < count; c++) begin
            n = 0;
            while (txd !== 1'b0 && n < 4000) begin
                next_cycle();
                n++;
            end
            if (txd !== 1'b0) begin
                $display("timeout waiting for a start bit on txd");
                errors++;
                return;
            end
            repeat (clks_per_bit / 2) next_cycle();
            expect_bit("txd start bit", txd, 1'b0);
            for (int i = 0; i < byte_width; i++) begin
                repeat (clks_per_bit) next_cycle();
                got[i] = txd;
            end
            repeat (clks_per_bit) next_cycle();
            expect_bit("txd stop bit", txd, 1'b1);
            if (expected_chars.size() == 0) begin
                $display("character %h appeared on txd with no nonce outstanding", got);
                errors++;
            end else begin
                want = expected_chars.pop_front();
                assert (got == want) else begin
                    $display("** Error: txd character = %h, expected %h", got, want);
                    errors++;
                end
            end
            chars_pending--;
        end
    endtask

    task automatic close_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, errors - errors_before);
        errors_before = errors;
    endtask

    data_on_req: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(header_req) |-> header_data == expected_header)
        else begin
            $display("** Error: header_data = %h, expected %h", header_data, expected_header);
            errors++;
        end

    data_held: assert property (@(posedge clock) disable iff (!rst_n)
        header_req |-> $stable(header_data))
        else begin
            $display("** Error: header_data = %h changed while header_req was high", header_data);
            errors++;
        end

    req_waits_ack: assert property (@(posedge clock) disable iff (!rst_n)
        header_req && !header_ack |=> header_req)
        else begin
            $display("** Error: header_req = %h before header_ack, expected 1", header_req);
            errors++;
        end

    req_drops: assert property (@(posedge clock) disable iff (!rst_n)
        header_req && header_ack |=> !header_req)
        else begin
            $display("** Error: header_req = %h after header_ack, expected 0", header_req);
            errors++;
        end

    overrun_quiet: assert property (@(posedge clock) disable iff (!rst_n)
        !overrun_expected |-> !overrun)
        else begin
            $display("** Error: overrun = %h, expected 0", overrun);
            errors++;
        end

    // the core may let go of req as soon as it sees ack.
    ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(nonce_ack) |-> $past(nonce_req))
        else begin
            $display("nonce_ack rose without nonce_req");
            errors++;
        end

    ack_held_back: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(nonce_ack) |-> $past(chars_pending) == 0)
        else begin
            $display("nonce_ack rose while %0d nonce characters were still unsent", chars_pending);
            errors++;
        end

    ack_drops: assert property (@(posedge clock) disable iff (!rst_n)
        nonce_ack && !nonce_req |=> !nonce_ack)
        else begin
            $display("** Error: nonce_ack = %h after nonce_req fell, expected 0", nonce_ack);
            errors++;
        end

    txd_idle: assert property (@(posedge clock) disable iff (!rst_n)
        chars_pending == 0 |-> txd)
        else begin
            $display("** Error: txd = %h with no nonce outstanding, expected 1", txd);
            errors++;
        end

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        rxd = 1'b1;
        header_ack = 1'b0;
        nonce_req = 1'b0;
        nonce = '0;
        lfsr = 32'h739c_bf91;
        expected_header = '0;
        overrun_expected = 1'b0;
        chars_pending = 0;
        errors = 0;
        errors_before = 0;
        test_count = 0;

        repeat (16) @(posedge clock);
        #drive_delay;
        rst_n = 1'b1;
        next_cycle();
        expect_bit("txd", txd, 1'b1);
        expect_bit("header_req", header_req, 1'b0);
        expect_bit("nonce_ack", nonce_ack, 1'b0);
        expect_bit("overrun", overrun, 1'b0);
        close_test("reset state");

        send_header_bytes(header_bytes);
        wait_header_req(1'b1, 100);
        close_test("first header");

        ack_header();
        send_header_bytes(header_bytes);
        wait_header_req(1'b1, 100);
        ack_header();
        close_test("header handshake and second header");

        // one byte while the handshake is open, then one framing error.
        send_header_bytes(header_bytes);
        wait_header_req(1'b1, 100);
        overrun_expected = 1'b1;
        send_byte(byte_width'(random_bits(byte_width)), 1'b1);
        expect_bit("overrun", overrun, 1'b1);
        assert (header_data == expected_header) else begin
            $display("** Error: header_data = %h, expected %h", header_data, expected_header);
            errors++;
        end
        ack_header();
        send_byte(byte_width'(random_bits(byte_width)), 1'b0);
        send_header_bytes(header_bytes - 1);
        repeat (3 * clks_per_bit) next_cycle();
        expect_bit("header_req", header_req, 1'b0);
        send_header_bytes(1);
        wait_header_req(1'b1, 100);
        ack_header();
        close_test("overrun and bad stop bit");

        fork
            offer_nonce(random_bits(nonce_width));
            receive_chars(nonce_bytes);
        join
        close_test("single nonce");

        first_nonce = random_bits(nonce_width);
        second_nonce = random_bits(nonce_width);
        fork
            begin
                offer_nonce(first_nonce);
                wait_pending_below(nonce_bytes, 1000);
                offer_nonce(second_nonce);
            end
            receive_chars(2 * nonce_bytes);
        join
        assert (expected_chars.size() == 0) else begin
            $display("%0d nonce characters never appeared on txd", expected_chars.size());
            errors++;
        end
        close_test("nonce back-pressure");

        $display("%0d tests, %0d errors", test_count, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- all.f
src/miner_link_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/header_assembler.sv
src/nonce_serializer.sv
src/link_ctrl.sv
src/miner_uart_link.sv
testbench/tb_miner_uart_link.sv

//--- build.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and check the log for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --timescale 1ns/100ps \
    --top-module tb_miner_uart_link -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_miner_uart_link > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
exit 1
